// ==== flist.f ====
source/sv32_pkg.sv
source/dtlb.sv
source/page_walker.sv
source/mem_arbiter.sv
source/pt_ram.sv
source/mmu_top.sv
testbench/clock_gen.sv
testbench/mmu_checker.sv
testbench/mmu_tb.sv

// ==== Makefile ====
# Verilator flow for the Sv32 MMU testbench

TOP := mmu_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f flist.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -j 0 -f flist.f --top-module $(TOP) -o mmu_sim
	./obj_dir/mmu_sim

clean:
	rm -rf obj_dir

// ==== testbench/mmu_tb.sv ====
/*
 * MMU testbench
 * Builds page tables over the host port, drives translations and compares
 * each answer with a reference Sv32 translation of the same tables
 */
module mmu_tb import sv32_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_NS     = 10;
    localparam int MEM_WORDS  = 4096;
    localparam int N_RAND     = 200;
    localparam int NUM_REQ    = N_RAND + 60;
    localparam int NUM_WRITES = 120;
    localparam int WORST_WALK = 6;   // Walk request, two levels, answer
    localparam int WATCHDOG_CYCLES = NUM_REQ * (WORST_WALK + 4) + NUM_WRITES * 2 + 50;

    localparam int LAT_ANY  = 0;
    localparam int LAT_HIT  = 1;
    localparam int LAT_WALK = 2;   // Anything longer than a hit

    localparam logic [7:0] F_SRW   = 8'hC7;
    localparam logic [7:0] F_URW   = 8'hD7;
    localparam logic [7:0] F_XO    = 8'hC9;
    localparam logic [7:0] F_CLEAN = 8'h47;
    localparam logic [7:0] F_WNR   = 8'hC5;
    localparam logic [7:0] F_GRW   = 8'hE7;
    localparam logic [7:0] F_SRO   = 8'hC3;

    logic        clk;
    logic        rst_n;
    mmu_ctrl_t   ctrl;
    tlb_req_t    req;
    sfence_t     sfence;
    mem_req_t    host;
    tlb_resp_t   resp;

    logic [31:0] pt [int];   // Copy of the page table RAM
    int          cyc = 0;
    int          done_count;
    int          issued;
    bit          pending;
    tlb_resp_t   exp_resp;
    int          exp_kind;
    int          start_cyc;
    logic [31:0] cur_va;

    clock_gen clk0 (.clk(clk), .rst_n(rst_n));

    mmu_top #(
        .WAYS     (2),
        .DEPTH    (16),
        .MEM_WORDS(MEM_WORDS)
    ) dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .ctrl  (ctrl),
        .req   (req),
        .sfence(sfence),
        .host  (host),
        .resp  (resp)
    );

    always @(posedge clk) cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // Reference model
    function automatic logic [31:0] pte_at(int word);
        return pt.exists(word) ? pt[word] : 32'h0;
    endfunction

    function automatic logic access_allowed(pte_flags_t f, logic rnw, mmu_ctrl_t c);
        if (!f.a)
            return 1'b0;
        if (rnw && !(f.r || (c.mxr && f.x)))
            return 1'b0;
        if (!rnw && !(f.w && f.d))
            return 1'b0;
        if (c.privilege == PRIV_U)
            return f.u;
        return !f.u || c.sum;
    endfunction

    function automatic tlb_resp_t translate_ref(logic [31:0] va, logic rnw, mmu_ctrl_t c);
        pte_u      p1;
        pte_u      p0;
        int        w1;
        int        w0;
        tlb_resp_t r;
        r = '{done: 1'b1, fault: 1'b0, paddr: va};
        if (!c.translation_on)
            return r;
        w1 = ((int'(c.root_ppn) << 10) | int'(va[31:22])) % MEM_WORDS;
        p1 = pte_at(w1);
        r.fault = 1'b1;
        if (!p1.leaf_view.flags.v || (p1.leaf_view.flags.w && !p1.leaf_view.flags.r))
            return r;
        if (p1.leaf_view.flags.r || p1.leaf_view.flags.x) begin
            if (p1.leaf_view.ppn0 != 10'd0)
                return r;   // Superpage must be 4 MiB aligned
            r.fault = !access_allowed(p1.leaf_view.flags, rnw, c);
            r.paddr = {p1.leaf_view.ppn1[9:0], va[21:0]};
            return r;
        end
        w0 = ((int'(p1.pointer_view.ppn[19:0]) << 10) | int'(va[21:12])) % MEM_WORDS;
        p0 = pte_at(w0);
        if (!p0.leaf_view.flags.v || (p0.leaf_view.flags.w && !p0.leaf_view.flags.r))
            return r;
        if (!(p0.leaf_view.flags.r || p0.leaf_view.flags.x))
            return r;   // No third level
        r.fault = !access_allowed(p0.leaf_view.flags, rnw, c);
        r.paddr = {p0.leaf_view.ppn1[9:0], p0.leaf_view.ppn0, va[11:0]};
        return r;
    endfunction

    function automatic logic [31:0] leaf(logic [21:0] ppn, logic [7:0] flags);
        return {ppn, 2'b00, flags};
    endfunction

    function automatic logic [31:0] pointer(int ppn);
        return {22'(ppn), 2'b00, 8'h01};
    endfunction

    function automatic logic [31:0] va4k(int vpn1, int vpn0, int off);
        return {10'(vpn1), 10'(vpn0), 12'(off)};
    endfunction

    //////////////////////////////////////////////////
    // Checks
    task automatic fail_now(string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1, "run stopped at first failure");
    endtask

    task automatic check_resp(tlb_resp_t got, tlb_resp_t exp);
        if (got.fault !== exp.fault)
            fail_now($sformatf("error %0t ns: va %h fault %0b, expected %0b",
                               $time, cur_va, got.fault, exp.fault));
        else if (!exp.fault && got.paddr !== exp.paddr)
            fail_now($sformatf("error %0t ns: va %h paddr %h, expected %h",
                               $time, cur_va, got.paddr, exp.paddr));
    endtask

    task automatic check_latency(int got, int kind);
        if (kind == LAT_HIT && got != 1)
            fail_now($sformatf("error %0t ns: va %h answered after %0d cycles, expected 1",
                               $time, cur_va, got));
        else if (kind == LAT_WALK && got <= 1)
            fail_now($sformatf("error %0t ns: va %h answered after %0d cycles, expected a walk",
                               $time, cur_va, got));
    endtask

    // Compare each answer at the falling edge, where resp is settled
    always begin
        @(negedge clk);
        if (rst_n && resp.done) begin
            if (!pending)
                fail_now("The DUT answered without a pending request");
            check_resp(resp, exp_resp);
            check_latency(cyc - start_cyc, exp_kind);
            pending = 1'b0;
            done_count++;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_NS);
        fail_now($sformatf("The run did not finish within %0d cycles", WATCHDOG_CYCLES));
    end

    //////////////////////////////////////////////////
    // Stimulus tasks
    task automatic write_pte(int word, logic [31:0] val);
        @(negedge clk);
        host   = '{strobe: 1'b1, we: 1'b1, addr: 32'(word), wdata: val};
        pt[word] = val;
        @(negedge clk);
        host   = '0;
    endtask

    task automatic set_ctrl(mmu_ctrl_t c);
        @(negedge clk);
        ctrl = c;
    endtask

    task automatic fence(logic [31:0] addr, logic addr_only);
        @(negedge clk);
        sfence = '{strobe: 1'b1, addr_only: addr_only, addr: addr};
        @(negedge clk);
        sfence = '0;
    endtask

    task automatic issue(logic [31:0] va, logic rnw, int kind);
        int target;
        @(negedge clk);
        exp_resp  = translate_ref(va, rnw, ctrl);
        exp_kind  = kind;
        start_cyc = cyc;
        cur_va    = va;
        pending   = 1'b1;
        target    = done_count + 1;
        issued++;
        req       = '{strobe: 1'b1, vaddr: va, rnw: rnw};
        @(negedge clk);
        req.strobe = 1'b0;
        while (done_count < target)
            @(negedge clk);
    endtask

    task automatic build_tables();
        logic [7:0] pick [3];
        pick = '{F_SRW, F_URW, F_SRO};
        write_pte(1, pointer(1));
        write_pte(2, leaf(22'h1400, F_SRW));   // Superpage
        write_pte(3, leaf(22'h1401, F_SRW));   // Misaligned superpage
        write_pte(4, pointer(2));
        write_pte(5, leaf(22'h1800, F_GRW));   // Global superpage
        write_pte(6, pointer(3));
        for (int i = 0; i < 8; i++)
            write_pte(1024 + i, leaf(22'(32'h400 + i), F_SRW));
        write_pte(1024 + 8, leaf(22'h500, F_URW));
        write_pte(1024 + 9, leaf(22'h501, F_XO));
        write_pte(1024 + 10, leaf(22'h502, F_CLEAN));
        write_pte(1024 + 11, 32'h0);
        write_pte(1024 + 12, leaf(22'h503, F_WNR));
        write_pte(1024 + 13, leaf(22'h504, F_GRW));
        for (int i = 14; i < 32; i++)
            write_pte(1024 + i, 32'h0);   // Rest of the table invalid
        for (int t = 2; t < 4; t++) begin
            for (int i = 0; i < 32; i++)
                write_pte(t * 1024 + i, leaf(22'($urandom), pick[$urandom % 3]));
        end
    endtask

    //////////////////////////////////////////////////
    // Test sequence
    initial begin
        mmu_ctrl_t   c;
        logic [31:0] sp_va;
        logic [31:0] g_va;
        int          vpn1_opts [5];
        vpn1_opts = '{1, 2, 4, 5, 6};
        void'($urandom(32'h32f5));
        ctrl = '{translation_on: 1'b0, root_ppn: 20'd0, asid: 9'd1,
                 privilege: PRIV_S, sum: 1'b0, mxr: 1'b0};
        req        = '0;
        sfence     = '0;
        host       = '0;
        pending    = 1'b0;
        done_count = 0;
        issued     = 0;
        wait (rst_n === 1'b1);
        build_tables();

        repeat (8) issue($urandom, 1'($urandom), LAT_HIT);   // Bare mode

        c = ctrl;
        c.translation_on = 1'b1;
        set_ctrl(c);
        for (int i = 0; i < 8; i++) begin
            issue(va4k(1, i, i * 100), 1'b1, LAT_WALK);
            issue(va4k(1, i, i * 100), 1'b0, LAT_HIT);
        end
        sp_va = {10'd2, 22'($urandom)};
        sp_va[15] = 1'b1;   // Upper half of the sets, away from page 1.0
        issue(sp_va, 1'b1, LAT_WALK);
        issue(sp_va, 1'b1, LAT_HIT);

        // Faults
        issue(va4k(1, 11, 0), 1'b1, LAT_WALK);
        issue(va4k(1, 12, 4), 1'b1, LAT_WALK);
        issue({10'd3, 22'h1234}, 1'b1, LAT_WALK);
        issue(va4k(1, 10, 8), 1'b1, LAT_WALK);
        issue(va4k(1, 10, 8), 1'b0, LAT_HIT);    // Clean page
        c.privilege = PRIV_U;
        set_ctrl(c);
        issue(va4k(1, 0, 0), 1'b1, LAT_HIT);
        issue(va4k(1, 8, 0), 1'b1, LAT_WALK);
        c.privilege = PRIV_S;
        set_ctrl(c);
        issue(va4k(1, 8, 0), 1'b1, LAT_HIT);
        c.sum = 1'b1;
        set_ctrl(c);
        issue(va4k(1, 8, 0), 1'b1, LAT_HIT);
        c.sum = 1'b0;
        set_ctrl(c);
        issue(va4k(1, 9, 0), 1'b1, LAT_WALK);
        c.mxr = 1'b1;
        set_ctrl(c);
        issue(va4k(1, 9, 0), 1'b1, LAT_HIT);
        c.mxr = 1'b0;
        set_ctrl(c);

        // ASID switch
        g_va = {10'd5, 22'h3ff000};
        issue(va4k(1, 13, 0), 1'b1, LAT_WALK);
        issue(g_va, 1'b1, LAT_WALK);
        c.asid = 9'd2;
        set_ctrl(c);
        issue(va4k(1, 0, 16), 1'b1, LAT_WALK);
        issue(va4k(1, 13, 0), 1'b1, LAT_HIT);
        issue(g_va, 1'b1, LAT_HIT);

        // SFENCE by address, then flush-all
        c.asid = 9'd1;   // Back to the ASID the cached pages were filled under
        set_ctrl(c);
        write_pte(1024 + 2, leaf(22'h777, F_SRW));
        fence(va4k(1, 2, 0), 1'b1);
        issue(va4k(1, 2, 0), 1'b1, LAT_WALK);
        for (int i = 0; i < 8; i++)
            write_pte(1024 + i, leaf(22'(32'h900 + i), F_SRW));
        write_pte(2, leaf(22'h1c00, F_SRW));
        fence(32'h0, 1'b0);
        for (int i = 0; i < 8; i++)
            issue(va4k(1, i, i * 4), 1'b1, LAT_WALK);
        issue(sp_va, 1'b1, LAT_WALK);

        // Mixed traffic, six pages per set
        repeat (N_RAND) begin
            c.sum       = 1'($urandom);
            c.mxr       = 1'($urandom);
            c.privilege = priv_t'(($urandom % 4) != 0);
            set_ctrl(c);
            issue(va4k(vpn1_opts[$urandom % 5], int'($urandom % 32), int'($urandom % 4096)),
                  1'($urandom), LAT_ANY);
        end

        repeat (2) @(negedge clk);
        if (!pending && done_count == issued) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Request count and answer count differ at the end");
            $display("Testbench failed");
            $fatal(1, "run ended with requests unanswered");
        end
    end

endmodule

// ==== testbench/mmu_checker.sv ====
/*
 * Handshake assertions
 * Bound once to the TLB and once to the arbiter
 */
module mmu_checker #(
    parameter bit FIXED_LAT = 1'b0   // Answer always one cycle after start
) (
    input logic clk,
    input logic rst_n,
    input logic start,
    input logic done,
    input logic excl_a,
    input logic excl_b
);
    timeunit 1ns;
    timeprecision 100ps;

    start_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        start |=> !start)
        else $error("start held longer than one cycle");

    done_is_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        done |=> !done)
        else $error("done held longer than one cycle");

    exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        excl_a |-> !excl_b)
        else $error("mutually exclusive signals both high");

    if (FIXED_LAT) begin : g_fixed
        one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
            start |=> done)
            else $error("answer did not follow start by one cycle");
    end

endmodule

// TLB: one request at a time, walker never answers during a lookup
bind dtlb mmu_checker #(.FIXED_LAT(1'b0)) tlb_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .start (req.strobe),
    .done  (resp.done),
    .excl_a(walk_resp.done),
    .excl_b(lookup_r)
);

// Arbiter: granted read returns next cycle, walker quiet while it waits
bind mem_arbiter mmu_checker #(.FIXED_LAT(1'b1)) arb_chk (
    .clk   (clk),
    .rst_n (rst_n),
    .start (walker_grant),
    .done  (walker_rsp.valid),
    .excl_a(walker_rsp.valid),
    .excl_b(walker_req.strobe)
);

// ==== testbench/clock_gen.sv ====
/*
 * Testbench clock and reset
 * 10 ns clock, active-low reset held for three cycles
 */
module clock_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk   = 1'b0;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;   // Released away from the active edge
    end

    always #5 clk = ~clk;

endmodule

// ==== source/mmu_top.sv ====
/*
 * Data-side Sv32 MMU
 * TLB in front of a hardware walker, which shares the page table RAM with
 * a host write port
 */
module mmu_top import sv32_pkg::*; #(
    parameter int WAYS      = 2,
    parameter int DEPTH     = 16,
    parameter int MEM_WORDS = 4096
) (
    input  logic      clk,
    input  logic      rst_n,
    input  mmu_ctrl_t ctrl,
    input  tlb_req_t  req,
    input  sfence_t   sfence,
    input  mem_req_t  host,
    output tlb_resp_t resp
);

    walk_req_t  walk_req;
    walk_resp_t walk_resp;
    mem_req_t   walker_mem_req;
    logic       walker_grant;
    mem_rsp_t   walker_rsp;
    mem_req_t   ram_req;
    mem_rsp_t   ram_rsp;

    dtlb #(
        .WAYS (WAYS),
        .DEPTH(DEPTH)
    ) dtlb0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .req      (req),
        .sfence   (sfence),
        .walk_resp(walk_resp),
        .walk_req (walk_req),
        .resp     (resp)
    );

    page_walker walker0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .ctrl     (ctrl),
        .walk_req (walk_req),
        .grant    (walker_grant),
        .mem_rsp  (walker_rsp),
        .mem_req  (walker_mem_req),
        .walk_resp(walk_resp)
    );

    mem_arbiter #(
        .MEM_WORDS(MEM_WORDS)
    ) arb0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .host        (host),
        .walker_req  (walker_mem_req),
        .walker_grant(walker_grant),
        .walker_rsp  (walker_rsp),
        .ram_req     (ram_req),
        .ram_rsp     (ram_rsp)
    );

    pt_ram #(
        .MEM_WORDS(MEM_WORDS)
    ) ram0 (
        .clk    (clk),
        .ram_req(ram_req),
        .ram_rsp(ram_rsp)
    );

endmodule

// ==== source/pt_ram.sv ====
/*
 * Page table memory, one 32-bit word per address, registered read
 */
module pt_ram import sv32_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic     clk,
    input  mem_req_t ram_req,
    output mem_rsp_t ram_rsp
);

    localparam int AW = $clog2(MEM_WORDS);

    logic [31:0]   mem [MEM_WORDS];
    logic [AW-1:0] idx;

    assign idx = ram_req.addr[AW-1:0];

    always_ff @(posedge clk) begin
        if (ram_req.strobe && ram_req.we)
            mem[idx] <= ram_req.wdata;
    end

    // Data and valid one cycle after the read strobe
    always_ff @(posedge clk) begin
        ram_rsp.valid <= ram_req.strobe & ~ram_req.we;
        ram_rsp.rdata <= mem[idx];
    end

endmodule

// ==== source/mem_arbiter.sv ====
/*
 * Page table RAM arbiter
 * Host port has fixed priority, walker waits; read data is steered back
 * to whoever owns the read in flight
 */
module mem_arbiter import sv32_pkg::*; #(
    parameter int MEM_WORDS = 4096
) (
    input  logic     clk,
    input  logic     rst_n,
    input  mem_req_t host,
    input  mem_req_t walker_req,
    output logic     walker_grant,
    output mem_rsp_t walker_rsp,
    output mem_req_t ram_req,
    input  mem_rsp_t ram_rsp
);

    localparam int AW = $clog2(MEM_WORDS);

    mem_req_t sel_req;
    logic     walker_owns_r;   // Read in flight belongs to the walker

    assign walker_grant = walker_req.strobe & ~host.strobe;
    assign sel_req      = host.strobe ? host : walker_req;

    // Out-of-range addresses wrap
    always_comb begin
        ram_req      = sel_req;
        ram_req.addr = {{(32 - AW){1'b0}}, sel_req.addr[AW-1:0]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            walker_owns_r <= 1'b0;
        else
            walker_owns_r <= walker_grant;
    end

    assign walker_rsp.valid = ram_rsp.valid & walker_owns_r;
    assign walker_rsp.rdata = ram_rsp.rdata;

endmodule

// ==== source/page_walker.sv ====
/*
 * Sv32 page table walker
 * Two-level walk from root_ppn, one PTE read per level through the arbiter,
 * ends with a refill for the TLB or a fault
 */
module page_walker import sv32_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  mmu_ctrl_t  ctrl,
    input  walk_req_t  walk_req,
    input  logic       grant,
    input  mem_rsp_t   mem_rsp,
    output mem_req_t   mem_req,
    output walk_resp_t walk_resp
);

    typedef enum logic [1:0] {
        W_IDLE,
        W_FETCH,   // Strobe held until granted
        W_WAIT     // PTE arrives
    } walk_state_t;

    walk_state_t state;
    logic        level1;     // Set while on the root table
    logic [31:0] vaddr_r;
    logic [19:0] base_ppn;

    pte_u        pte;
    logic        pte_bad;
    logic        pte_leaf;
    logic        pte_done;

    //////////////////////////////////////////////////
    // PTE decode
    assign pte      = mem_rsp.rdata;
    assign pte_bad  = ~pte.leaf_view.flags.v | (pte.leaf_view.flags.w & ~pte.leaf_view.flags.r);
    assign pte_leaf = pte.leaf_view.flags.r | pte.leaf_view.flags.x;
    assign pte_done = (state == W_WAIT) & mem_rsp.valid;

    always_comb begin
        walk_resp.done      = pte_done & (pte_bad | pte_leaf | ~level1);
        walk_resp.superpage = level1;
        walk_resp.ppn       = {pte.leaf_view.ppn1[9:0], pte.leaf_view.ppn0};
        walk_resp.flags     = pte.leaf_view.flags;
        if (pte_bad)
            walk_resp.fault = 1'b1;
        else if (pte_leaf)
            walk_resp.fault = level1 & (pte.leaf_view.ppn0 != '0);   // Misaligned superpage
        else
            walk_resp.fault = ~level1;   // Pointer on the last level
    end

    //////////////////////////////////////////////////
    // PTE fetch
    assign mem_req.strobe = (state == W_FETCH);
    assign mem_req.we     = 1'b0;
    assign mem_req.wdata  = '0;
    assign mem_req.addr   = level1 ? {2'b00, base_ppn, vaddr_r[31:22]}
                                   : {2'b00, base_ppn, vaddr_r[21:12]};

    always_ff @(posedge clk) begin
        if (state == W_IDLE && walk_req.strobe) begin
            vaddr_r  <= walk_req.vaddr;
            base_ppn <= ctrl.root_ppn;
        end else if (pte_done && !pte_bad && !pte_leaf && level1) begin
            base_ppn <= pte.pointer_view.ppn[19:0];   // PPN cut to 20 bits
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state  <= W_IDLE;
            level1 <= 1'b1;
        end else begin
            case (state)
                W_IDLE: begin
                    if (walk_req.strobe) begin
                        state  <= W_FETCH;
                        level1 <= 1'b1;
                    end
                end
                W_FETCH: begin
                    if (grant)
                        state <= W_WAIT;
                end
                W_WAIT: begin
                    if (walk_resp.done) begin
                        state <= W_IDLE;
                    end else if (mem_rsp.valid) begin
                        state  <= W_FETCH;   // Descend to level 0
                        level1 <= 1'b0;
                    end
                end
                default: state <= W_IDLE;
            endcase
        end
    end

endmodule

// ==== source/dtlb.sv ====
/*
 * Data TLB
 * Set-associative translation cache with ASID and global matching, Sv32
 * permission check, SFENCE support and round-robin refill from the walker
 */
module dtlb import sv32_pkg::*; #(
    parameter int WAYS  = 2,
    parameter int DEPTH = 16
) (
    input  logic       clk,
    input  logic       rst_n,
    input  mmu_ctrl_t  ctrl,
    input  tlb_req_t   req,
    input  sfence_t    sfence,
    input  walk_resp_t walk_resp,
    output walk_req_t  walk_req,
    output tlb_resp_t  resp
);

    localparam int IDX_W = $clog2(DEPTH);
    localparam int LOW_W = 10 - IDX_W;   // VPN0 bits above the index

    typedef struct packed {
        logic [9:0]        upper_tag;
        logic [LOW_W-1:0]  lower_tag;
        logic [ASID_W-1:0] asid;
        logic              superpage;
        logic [19:0]       ppn;
        pte_flags_t        flags;
    } tlb_entry_t;

    function automatic logic perm_ok(pte_flags_t f, logic rnw, mmu_ctrl_t c);
        logic ok;
        ok = f.a;
        if (rnw)
            ok = ok & (f.r | (f.x & c.mxr));
        else
            ok = ok & f.w & f.d;
        if (c.privilege == PRIV_U)
            ok = ok & f.u;
        else if (f.u)
            ok = ok & c.sum;   // S-mode into U page
        return ok;
    endfunction

    tlb_entry_t                  entries [WAYS][DEPTH];
    logic [WAYS-1:0][DEPTH-1:0]  valid;
    logic [WAYS-1:0][DEPTH-1:0]  flush_match;
    logic [WAYS-1:0]             repl_way;
    logic [2*WAYS-1:0]           repl_next;

    tlb_entry_t                  rd [WAYS];
    logic [IDX_W-1:0]            req_idx;
    logic [WAYS-1:0]             way_hit;
    logic [WAYS-1:0]             way_perm;
    logic [19:0]                 sel_ppn;
    logic                        sel_super;

    logic                        lookup_r;
    logic [31:0]                 vaddr_r;
    logic                        rnw_r;
    logic                        hit_r;
    logic                        fail_r;
    logic                        super_r;
    logic [19:0]                 ppn_r;
    logic                        refill;
    logic [IDX_W-1:0]            refill_idx;

    //////////////////////////////////////////////////
    // Lookup, set read combinationally
    assign req_idx = req.vaddr[12 +: IDX_W];

    always_comb begin
        way_hit   = '0;
        way_perm  = '0;
        sel_ppn   = '0;
        sel_super = 1'b0;
        for (int w = 0; w < WAYS; w++) begin
            rd[w] = entries[w][req_idx];
            way_hit[w] = valid[w][req_idx]
                       && rd[w].upper_tag == req.vaddr[31:22]
                       && (rd[w].superpage || rd[w].lower_tag == req.vaddr[21 -: LOW_W])
                       && (rd[w].asid == ctrl.asid || rd[w].flags.g);
            way_perm[w] = perm_ok(rd[w].flags, req.rnw, ctrl);
            if (way_hit[w]) begin
                sel_ppn   = sel_ppn | rd[w].ppn;
                sel_super = sel_super | rd[w].superpage;
            end
        end
    end

    // Compare and permission outcome held for the answer cycle
    always_ff @(posedge clk) begin
        if (req.strobe) begin
            vaddr_r <= req.vaddr;
            rnw_r   <= req.rnw;
            hit_r   <= |way_hit;
            fail_r  <= |(way_hit & ~way_perm);
            ppn_r   <= sel_ppn;
            super_r <= sel_super;
        end
    end

    //////////////////////////////////////////////////
    // SFENCE by address checks every set, superpages may sit anywhere
    always_comb begin
        for (int w = 0; w < WAYS; w++) begin
            for (int s = 0; s < DEPTH; s++) begin
                flush_match[w][s] = entries[w][s].upper_tag == sfence.addr[31:22]
                    && (entries[w][s].superpage
                        || (entries[w][s].lower_tag == sfence.addr[21 -: LOW_W]
                            && IDX_W'(s) == sfence.addr[12 +: IDX_W]));
            end
        end
    end

    //////////////////////////////////////////////////
    // Refill
    assign refill     = walk_resp.done & ~walk_resp.fault;
    assign refill_idx = vaddr_r[12 +: IDX_W];
    assign repl_next  = {repl_way, repl_way} >> (WAYS - 1);   // Rotate left by one

    always_ff @(posedge clk) begin
        if (refill) begin
            for (int w = 0; w < WAYS; w++) begin
                if (repl_way[w]) begin
                    entries[w][refill_idx] <= '{
                        upper_tag: vaddr_r[31:22],
                        lower_tag: vaddr_r[21 -: LOW_W],
                        asid:      ctrl.asid,
                        superpage: walk_resp.superpage,
                        ppn:       walk_resp.ppn,
                        flags:     walk_resp.flags
                    };
                end
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid    <= '0;
            repl_way <= WAYS'(1);
            lookup_r <= 1'b0;
        end else begin
            lookup_r <= req.strobe;
            if (sfence.strobe) begin
                if (sfence.addr_only)
                    valid <= valid & ~flush_match;
                else
                    valid <= '0;   // Flush all in one cycle
            end else if (refill) begin
                for (int w = 0; w < WAYS; w++) begin
                    if (repl_way[w])
                        valid[w][refill_idx] <= 1'b1;
                end
                repl_way <= repl_next[WAYS-1:0];
            end
        end
    end

    //////////////////////////////////////////////////
    // Answers and walk request
    assign walk_req.strobe = lookup_r & ctrl.translation_on & ~hit_r;
    assign walk_req.vaddr  = vaddr_r;

    always_comb begin
        resp.paddr[11:0] = vaddr_r[11:0];
        if (lookup_r) begin
            resp.done  = ~ctrl.translation_on | hit_r;
            resp.fault = ctrl.translation_on & hit_r & fail_r;
            if (!ctrl.translation_on)
                resp.paddr[31:12] = vaddr_r[31:12];
            else
                resp.paddr[31:12] = {ppn_r[19:10], super_r ? vaddr_r[21:12] : ppn_r[9:0]};
        end else begin
            // Refilled page answers straight from the walker
            resp.done  = walk_resp.done;
            resp.fault = walk_resp.fault | ~perm_ok(walk_resp.flags, rnw_r, ctrl);
            resp.paddr[31:12] = {walk_resp.ppn[19:10],
                                 walk_resp.superpage ? vaddr_r[21:12] : walk_resp.ppn[9:0]};
        end
    end

endmodule

// ==== source/sv32_pkg.sv ====
/*
 * Sv32 MMU shared types
 * PTE layout with leaf and pointer views, status fields, and the request and
 * response words passed between the load/store side, TLB, walker and memory
 */
package sv32_pkg;

    localparam int ASID_W = 9;

    // Low byte of every PTE
    typedef struct packed {
        logic d;
        logic a;
        logic g;
        logic u;
        logic x;
        logic w;
        logic r;
        logic v;
    } pte_flags_t;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
        logic [1:0]  rsw;
        pte_flags_t  flags;
    } pte_leaf_t;

    typedef struct packed {
        logic [21:0] ppn;   // Next table, full PPN
        logic [1:0]  rsw;
        pte_flags_t  flags;
    } pte_pointer_t;

    // One fetched word, read as a leaf or as a pointer
    typedef union packed {
        pte_leaf_t    leaf_view;
        pte_pointer_t pointer_view;
    } pte_u;

    typedef enum logic {
        PRIV_U = 1'b0,
        PRIV_S = 1'b1
    } priv_t;

    typedef struct packed {
        logic              translation_on;
        logic [19:0]       root_ppn;
        logic [ASID_W-1:0] asid;
        priv_t             privilege;
        logic              sum;
        logic              mxr;
    } mmu_ctrl_t;

    typedef struct packed {
        logic        strobe;
        logic [31:0] vaddr;
        logic        rnw;
    } tlb_req_t;

    typedef struct packed {
        logic        done;
        logic        fault;
        logic [31:0] paddr;
    } tlb_resp_t;

    typedef struct packed {
        logic        strobe;
        logic        addr_only;   // Clear for flush-all
        logic [31:0] addr;
    } sfence_t;

    typedef struct packed {
        logic        strobe;
        logic [31:0] vaddr;
    } walk_req_t;

    typedef struct packed {
        logic        done;
        logic        fault;
        logic        superpage;
        logic [19:0] ppn;
        pte_flags_t  flags;
    } walk_resp_t;

    typedef struct packed {
        logic        strobe;
        logic        we;
        logic [31:0] addr;   // Word address
        logic [31:0] wdata;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] rdata;
    } mem_rsp_t;

endpackage
